// ==== src/sk_cmd_pkg.sv ====
// Host command protocol for the front-end configuration port
package sk_cmd_pkg;

	////////////////////
	// Word format

	localparam int CMD_W = 16;                 // One host command word

	// Opcodes in the top nibble
	localparam logic [3:0] OP_SET_FIELD = 4'd1; // Write one setting byte
	localparam logic [3:0] OP_START_SC  = 4'd2; // Load image into ASIC
	localparam logic [3:0] OP_SET_DAC   = 4'd3; // Store code and write DAC
	localparam logic [3:0] OP_START_HV  = 4'd4; // Send HV setpoint

	// Field indices for OP_SET_FIELD
	localparam logic [3:0] FLD_CHIP_ID     = 4'd0;
	localparam logic [3:0] FLD_TRIG_DELAY  = 4'd1;
	localparam logic [3:0] FLD_DAC_TRIG_LO = 4'd2;  // Threshold bits 7..0
	localparam logic [3:0] FLD_DAC_TRIG_HI = 4'd3;  // Threshold bits 9..8
	localparam logic [3:0] FLD_MODE        = 4'd4;  // Feedback cap and trigger mode
	localparam logic [3:0] FLD_MASK3       = 4'd5;  // Mask bits 31..24
	localparam logic [3:0] FLD_MASK2       = 4'd6;
	localparam logic [3:0] FLD_MASK1       = 4'd7;
	localparam logic [3:0] FLD_MASK0       = 4'd8;  // Mask bits 7..0
	localparam logic [3:0] FLD_HV_HI       = 4'd9;
	localparam logic [3:0] FLD_HV_LO       = 4'd10;

	////////////////////
	// Two views of one word

	typedef struct packed {
		logic [3:0]       opcode;
		logic [CMD_W-5:0] code;               // 12-bit DAC code
	} cmd_dac_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] field;                    // Setting index
		logic [7:0] value;                    // Byte to write
	} cmd_field_t;

	typedef union packed {
		cmd_dac_t   dac;                      // OP_SET_DAC view
		cmd_field_t fld;                      // Everything else
	} cmd_word_u;

endpackage

// ==== src/sk_cfg_pkg.sv ====
// Chip register image and serial peripheral constants
package sk_cfg_pkg;

	////////////////////
	// Slow-control image

	// Shifted MSB first so chip_id leaves first
	typedef struct packed {
		logic [7:0]  chip_id;
		logic [7:0]  trig_delay;                // Trigger delay code
		logic [9:0]  dac_trigger;               // Discriminator threshold
		logic [3:0]  fb_cap;                    // Preamp feedback capacitance
		logic        en_discri;                 // Discriminator output enable
		logic        only_ex_trig;              // External trigger only
		logic [31:0] mask;                      // Channel mask
	} sc_image_t;

	localparam int SC_LEN = 64;

	localparam sc_image_t SC_RESET_IMAGE = '{
		chip_id:      8'h01,
		trig_delay:   8'h70,
		dac_trigger:  10'h000,
		fb_cap:       4'h0,
		en_discri:    1'b1,
		only_ex_trig: 1'b0,
		mask:         32'h0000_0000
	};

	localparam int SC_HALF   = 2;               // Cycles per sr_ck half period
	localparam int SC_BIT_W  = $clog2(SC_LEN);
	localparam int SC_HALF_W = $clog2(SC_HALF);

	////////////////////
	// Calibration DAC

	localparam logic [3:0] DAC_CTRL_A = 4'b1000; // Latch A in slow mode
	localparam int DAC_FRAME_W = 16;
	localparam int DAC_HALF    = 2;             // Cycles per sclk half period
	localparam int DAC_BIT_W   = $clog2(DAC_FRAME_W);
	localparam int DAC_HALF_W  = $clog2(DAC_HALF);

	////////////////////
	// HV module link

	localparam int          HV_DIGITS  = 4;     // Hex digits after prefix
	localparam logic [23:0] HV_PREFIX  = 24'h48_42_56; // ASCII HBV
	localparam int          HV_BYTES   = 7;
	localparam int          HV_BYTE_W  = $clog2(HV_BYTES);
	localparam int          UART_DIV   = 8;     // Clocks per bit
	localparam int          UART_DIV_W = $clog2(UART_DIV);
	localparam int          UART_FRAME = 10;    // Start, 8 data, stop
	localparam int          UART_BIT_W = $clog2(UART_FRAME);

endpackage

// ==== src/cmd_control.sv ====
// Command decoder and setting store that launches the serial engines
`timescale 1ns/1ps

module cmd_control
(
	input  logic                  Clk_Out_2_All,
	input  logic                  rst_n_i,
	input  sk_cmd_pkg::cmd_word_u cmd_i,        // Word from host
	input  logic                  cmd_valid_i,
	output logic                  cmd_ready_o,
	input  logic                  sc_busy_i,    // Engine busy levels
	input  logic                  dac_busy_i,
	input  logic                  hv_busy_i,
	output sk_cfg_pkg::sc_image_t sc_image_o,   // Register image to shifter
	output logic                  sc_start_o,
	output logic [11:0]           dac_code_o,
	output logic                  dac_start_o,
	output logic [15:0]           hv_value_o,   // HV setpoint in binary
	output logic                  hv_start_o
);
	import sk_cmd_pkg::*;
	import sk_cfg_pkg::*;

	logic       xfer;                         // Word accepted this cycle
	logic       start_pend;                   // Start pulse not yet seen as busy
	logic [3:0] opcode;
	logic [3:0] field;
	logic [7:0] value;

	////////////////////
	// Handshake

	// A start pulse is in flight for one cycle before busy comes up
	assign start_pend  = sc_start_o | dac_start_o | hv_start_o;
	assign cmd_ready_o = ~(sc_busy_i | dac_busy_i | hv_busy_i | start_pend);
	assign xfer        = cmd_valid_i & cmd_ready_o;

	// Field view carries opcode for every command
	assign opcode = cmd_i.fld.opcode;
	assign field  = cmd_i.fld.field;
	assign value  = cmd_i.fld.value;

	////////////////////
	// Engine starts

	always_ff @(posedge Clk_Out_2_All or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			sc_start_o  <= 1'b0;
			dac_start_o <= 1'b0;
			hv_start_o  <= 1'b0;
		end
		else
		begin
			sc_start_o  <= xfer && (opcode == OP_START_SC);   // One cycle wide
			dac_start_o <= xfer && (opcode == OP_SET_DAC);    // Code lands same edge
			hv_start_o  <= xfer && (opcode == OP_START_HV);
		end
	end

	////////////////////
	// Setting registers

	always_ff @(posedge Clk_Out_2_All or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			sc_image_o <= SC_RESET_IMAGE;
			dac_code_o <= '0;
			hv_value_o <= '0;
		end
		else if (xfer)
		begin
			if (opcode == OP_SET_DAC)
				dac_code_o <= cmd_i.dac.code;          // DAC view of the word
			if (opcode == OP_SET_FIELD)
			begin
				case (field)
					FLD_CHIP_ID:     sc_image_o.chip_id           <= value;
					FLD_TRIG_DELAY:  sc_image_o.trig_delay        <= value;
					FLD_DAC_TRIG_LO: sc_image_o.dac_trigger[7:0]  <= value;
					FLD_DAC_TRIG_HI: sc_image_o.dac_trigger[9:8]  <= value[1:0];
					FLD_MODE:
					begin
						sc_image_o.fb_cap       <= value[3:0];
						sc_image_o.en_discri    <= value[4];
						sc_image_o.only_ex_trig <= value[5];
					end
					FLD_MASK3:       sc_image_o.mask[31:24]       <= value;
					FLD_MASK2:       sc_image_o.mask[23:16]       <= value;
					FLD_MASK1:       sc_image_o.mask[15:8]        <= value;
					FLD_MASK0:       sc_image_o.mask[7:0]         <= value;
					FLD_HV_HI:       hv_value_o[15:8]             <= value;
					FLD_HV_LO:       hv_value_o[7:0]              <= value;
					default:         ;                        // Indices 11..15 dropped
				endcase
			end
			// Other opcodes are accepted and leave the settings alone
		end
	end

endmodule

// ==== src/sc_shifter.sv ====
// Slow-control shifter that clocks the register image into the ASIC
`timescale 1ns/1ps

module sc_shifter
(
	input  logic                  Clk_Out_2_All,
	input  logic                  rst_n_i,
	input  sk_cfg_pkg::sc_image_t image_i,      // Image sampled at start
	input  logic                  start_i,
	output logic                  busy_o,
	output logic                  sr_ck_o,      // ASIC shift clock
	output logic                  sr_in_o       // ASIC shift data
);
	import sk_cfg_pkg::*;

	logic [SC_LEN-1:0]    shreg;              // Remaining bits
	logic [SC_HALF_W-1:0] half_cnt;           // Cycles into half period
	logic [SC_BIT_W-1:0]  bit_cnt;
	logic                 half_end;
	logic                 fall;               // sr_ck about to drop

	assign half_end = (half_cnt == SC_HALF_W'(SC_HALF - 1));
	assign fall     = busy_o && half_end && sr_ck_o;

	always_ff @(posedge Clk_Out_2_All or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			busy_o   <= 1'b0;
			sr_ck_o  <= 1'b0;
			sr_in_o  <= 1'b0;
			half_cnt <= '0;
			bit_cnt  <= '0;
		end
		else if (!busy_o)
		begin
			if (start_i)
			begin
				busy_o   <= 1'b1;
				sr_in_o  <= image_i[SC_LEN-1];    // MSB ready before first rise
				half_cnt <= '0;
				bit_cnt  <= '0;
			end
		end
		else if (half_end)
		begin
			half_cnt <= '0;
			sr_ck_o  <= ~sr_ck_o;
			if (sr_ck_o)                          // End of a full period
			begin
				if (bit_cnt == SC_BIT_W'(SC_LEN - 1))
				begin
					busy_o  <= 1'b0;
					sr_in_o <= 1'b0;                // Back to idle low
				end
				else
				begin
					bit_cnt <= bit_cnt + 1'b1;
					sr_in_o <= shreg[SC_LEN-2];     // Next bit while clock low
				end
			end
		end
		else
			half_cnt <= half_cnt + 1'b1;
	end

	// Image register shifts once per period
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!busy_o && start_i)
			shreg <= image_i;
		else if (fall)
			shreg <= shreg << 1;
	end

endmodule

// ==== src/dac_serial.sv ====
// Serial writer for the TLV5618-style calibration DAC
`timescale 1ns/1ps

module dac_serial
(
	input  logic        Clk_Out_2_All,
	input  logic        rst_n_i,
	input  logic [11:0] code_i,               // DAC code sampled at start
	input  logic        start_i,
	output logic        busy_o,
	output logic        sclk_o,
	output logic        din_o,                // Valid at falling sclk
	output logic        cs_n_o
);
	import sk_cfg_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_LO, ST_HI, ST_TAIL} dac_st_t;

	dac_st_t                state;
	logic [DAC_FRAME_W-1:0] frame_q;          // Control nibble and code
	logic [DAC_HALF_W-1:0]  half_cnt;
	logic [DAC_BIT_W-1:0]   bit_cnt;
	logic                   half_end;

	assign half_end = (half_cnt == DAC_HALF_W'(DAC_HALF - 1));
	assign busy_o   = (state != ST_IDLE);

	always_ff @(posedge Clk_Out_2_All or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state    <= ST_IDLE;
			half_cnt <= '0;
			bit_cnt  <= '0;
			sclk_o   <= 1'b0;
			din_o    <= 1'b0;
			cs_n_o   <= 1'b1;
		end
		else if (state == ST_IDLE)
		begin
			if (start_i)
			begin
				state    <= ST_LO;
				cs_n_o   <= 1'b0;                 // Frame opens
				din_o    <= DAC_CTRL_A[3];        // First bit set up early
				half_cnt <= '0;
				bit_cnt  <= '0;
			end
		end
		else if (!half_end)
			half_cnt <= half_cnt + 1'b1;
		else
		begin
			half_cnt <= '0;
			case (state)
				ST_LO:
				begin
					sclk_o <= 1'b1;
					din_o  <= frame_q[DAC_FRAME_W-1];   // Change on rising edge
					state  <= ST_HI;
				end
				ST_HI:
				begin
					sclk_o <= 1'b0;                     // DAC samples here
					if (bit_cnt == DAC_BIT_W'(DAC_FRAME_W - 1))
						state <= ST_TAIL;
					else
					begin
						bit_cnt <= bit_cnt + 1'b1;
						state   <= ST_LO;
					end
				end
				default:                              // Half period after last bit
				begin
					cs_n_o <= 1'b1;
					din_o  <= 1'b0;
					state  <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (state == ST_IDLE && start_i)
			frame_q <= {DAC_CTRL_A, code_i};
		else if (state == ST_LO && half_end)
			frame_q <= frame_q << 1;
	end

endmodule

// ==== src/hv_uart.sv ====
// HV setpoint sender that frames "HBV" and four hex digits over 8N1 serial
`timescale 1ns/1ps

module hv_uart
(
	input  logic        Clk_Out_2_All,
	input  logic        rst_n_i,
	input  logic [15:0] value_i,              // Setpoint sampled at start
	input  logic        start_i,
	output logic        busy_o,
	output logic        tx_o                  // Idle high
);
	import sk_cfg_pkg::*;

	logic [HV_DIGITS*8-1:0] digits_w;         // ASCII digits, MSD on top
	logic [HV_BYTES*8-1:0]  msg_w;
	logic [HV_BYTES*8-1:0]  msg_q;            // Bytes still to send
	logic [UART_FRAME-1:0]  frame_q;          // Current byte with start and stop
	logic [UART_DIV_W-1:0]  div_cnt;          // Bit timer
	logic [UART_BIT_W-1:0]  bit_cnt;
	logic [HV_BYTE_W-1:0]   byte_cnt;
	logic                   bit_end;
	logic                   byte_end;

	// Upper-case hex digit
	function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
		if (nib < 4'd10)
			return 8'h30 + {4'h0, nib};
		else
			return 8'h37 + {4'h0, nib};
	endfunction

	////////////////////
	// Message build

	always_comb
	begin
		for (int i = 0; i < HV_DIGITS; i++)
			digits_w[i*8 +: 8] = hex_ascii(value_i[i*4 +: 4]);
	end

	assign msg_w    = {HV_PREFIX, digits_w};
	assign bit_end  = busy_o && (div_cnt == UART_DIV_W'(UART_DIV - 1));
	assign byte_end = bit_end && (bit_cnt == UART_BIT_W'(UART_FRAME - 1));

	////////////////////
	// Bit and byte timing

	always_ff @(posedge Clk_Out_2_All or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			busy_o   <= 1'b0;
			tx_o     <= 1'b1;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			byte_cnt <= '0;
		end
		else if (!busy_o)
		begin
			if (start_i)
			begin
				busy_o   <= 1'b1;
				tx_o     <= 1'b0;                 // Start bit of first byte
				div_cnt  <= '0;
				bit_cnt  <= '0;
				byte_cnt <= '0;
			end
		end
		else if (!bit_end)
			div_cnt <= div_cnt + 1'b1;
		else
		begin
			div_cnt <= '0;
			if (byte_end)
			begin
				bit_cnt <= '0;
				if (byte_cnt == HV_BYTE_W'(HV_BYTES - 1))
				begin
					busy_o <= 1'b0;
					tx_o   <= 1'b1;
				end
				else
				begin
					byte_cnt <= byte_cnt + 1'b1;
					tx_o     <= 1'b0;               // Next byte follows at once
				end
			end
			else
			begin
				bit_cnt <= bit_cnt + 1'b1;
				tx_o    <= frame_q[1];            // LSB first
			end
		end
	end

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (!busy_o && start_i)
		begin
			frame_q <= {1'b1, msg_w[HV_BYTES*8-1 -: 8], 1'b0};
			msg_q   <= msg_w << 8;
		end
		else if (byte_end)
		begin
			frame_q <= {1'b1, msg_q[HV_BYTES*8-1 -: 8], 1'b0};
			msg_q   <= msg_q << 8;
		end
		else if (bit_end)
			frame_q <= {1'b1, frame_q[UART_FRAME-1:1]};
	end

endmodule

// ==== src/sk_top.sv ====
// Front-end configuration top joining the command decoder and serial engines
`timescale 1ns/1ps

module sk_top
(
	input  logic                  Clk_Out_2_All,
	input  logic                  rst_n_i,
	input  sk_cmd_pkg::cmd_word_u cmd_i,        // Host command port
	input  logic                  cmd_valid_i,
	output logic                  cmd_ready_o,
	output logic                  sr_ck_o,      // ASIC slow control
	output logic                  sr_in_o,
	output logic                  dac_sclk_o,   // Calibration DAC
	output logic                  dac_din_o,
	output logic                  dac_cs_n_o,
	output logic                  hv_tx_o       // HV module serial
);
	import sk_cfg_pkg::*;

	sc_image_t   sc_image;
	logic        sc_start;
	logic        sc_busy;
	logic [11:0] dac_code;
	logic        dac_start;
	logic        dac_busy;
	logic [15:0] hv_value;
	logic        hv_start;
	logic        hv_busy;

	cmd_control cmd_control_i (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_i       (rst_n_i),
		.cmd_i         (cmd_i),
		.cmd_valid_i   (cmd_valid_i),
		.cmd_ready_o   (cmd_ready_o),
		.sc_busy_i     (sc_busy),
		.dac_busy_i    (dac_busy),
		.hv_busy_i     (hv_busy),
		.sc_image_o    (sc_image),
		.sc_start_o    (sc_start),
		.dac_code_o    (dac_code),
		.dac_start_o   (dac_start),
		.hv_value_o    (hv_value),
		.hv_start_o    (hv_start)
	);

	sc_shifter sc_shifter_i (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_i       (rst_n_i),
		.image_i       (sc_image),
		.start_i       (sc_start),
		.busy_o        (sc_busy),
		.sr_ck_o       (sr_ck_o),
		.sr_in_o       (sr_in_o)
	);

	dac_serial dac_serial_i (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_i       (rst_n_i),
		.code_i        (dac_code),
		.start_i       (dac_start),
		.busy_o        (dac_busy),
		.sclk_o        (dac_sclk_o),
		.din_o         (dac_din_o),
		.cs_n_o        (dac_cs_n_o)
	);

	hv_uart hv_uart_i (
		.Clk_Out_2_All (Clk_Out_2_All),
		.rst_n_i       (rst_n_i),
		.value_i       (hv_value),
		.start_i       (hv_start),
		.busy_o        (hv_busy),
		.tx_o          (hv_tx_o)
	);

endmodule

// ==== tests/tb_clock.sv ====
// Testbench clock source and power-on reset pulse
`timescale 1ns/1ps

module tb_clock
(
	output logic Clk_Out_2_All,
	output logic rst_n_o
);

	initial
	begin
		Clk_Out_2_All = 1'b0;
		forever
			#2 Clk_Out_2_All = ~Clk_Out_2_All;   // 4 ns period
	end

	initial
	begin
		rst_n_o = 1'b1;
		#1;
		rst_n_o = 1'b0;                         // Falling edge fires async reset
		repeat (5) @(posedge Clk_Out_2_All);
		#3;
		rst_n_o = 1'b1;                         // Released between clock edges
	end

endmodule

// ==== tests/tb_properties.sv ====
// Bound protocol and idle-level assertions for the configuration top
`timescale 1ns/1ps

module tb_properties
(
	input logic                  Clk_Out_2_All,
	input logic                  rst_n_i,
	input sk_cmd_pkg::cmd_word_u cmd_i,
	input logic                  cmd_valid_i,
	input logic                  cmd_ready_o,
	input logic                  sr_ck_o,
	input logic                  dac_sclk_o,
	input logic                  dac_cs_n_o,
	input logic                  hv_tx_o
);
	import sk_cmd_pkg::*;

	int   fail_cnt = 0;                     // Failed property count
	logic start_xfer;                       // Start command accepted

	assign start_xfer = cmd_valid_i && cmd_ready_o &&
		(cmd_i.fld.opcode inside {OP_START_SC, OP_SET_DAC, OP_START_HV});

	////////////////////
	// DAC bus idle

	dac_clk_idle: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		dac_cs_n_o |-> !dac_sclk_o)
	else
	begin
		$error("dac_sclk_o is high while dac_cs_n_o is high");
		fail_cnt++;
	end

	// Serial lines parked during reset
	reset_idle: assert property (@(posedge Clk_Out_2_All)
		!rst_n_i |-> (hv_tx_o && !sr_ck_o && dac_cs_n_o))
	else
	begin
		$error("serial outputs not at idle levels during reset");
		fail_cnt++;
	end

	////////////////////
	// Handshake

	start_blocks: assert property (@(posedge Clk_Out_2_All) disable iff (!rst_n_i)
		start_xfer |=> !cmd_ready_o)
	else
	begin
		$error("cmd_ready_o still high the cycle after a start command");
		fail_cnt++;
	end

endmodule

bind sk_top tb_properties props_i (.*);

// ==== tests/tb_top.sv ====
// Testbench for the front-end configuration top with serial line decoders
`timescale 1ns/1ps

module tb_top;
	import sk_cmd_pkg::*;
	import sk_cfg_pkg::*;

	localparam int K_NONE = 0;              // Setting write without a serial job
	localparam int K_SC   = 1;
	localparam int K_DAC  = 2;
	localparam int K_HV   = 3;
	localparam int CLK_NS = 4;
	localparam int JOB_CYCLES = 600;        // HV job is 560 cycles

	logic      Clk_Out_2_All;
	logic      rst_n_i;
	cmd_word_u cmd_i;
	logic      cmd_valid_i;
	logic      cmd_ready_o;
	logic      sr_ck_o;
	logic      sr_in_o;
	logic      dac_sclk_o;
	logic      dac_din_o;
	logic      dac_cs_n_o;
	logic      hv_tx_o;

	// Stimulus table held as one queue per column
	string       tbl_name[$];
	logic [15:0] tbl_word[$];
	int          tbl_kind[$];
	logic [63:0] tbl_exp[$];

	// Expected settings
	logic [7:0]  m_chip_id    = 8'h01;
	logic [7:0]  m_trig_delay = 8'h70;
	logic [9:0]  m_dac_trig   = '0;
	logic [3:0]  m_fb_cap     = '0;
	logic        m_en_discri  = 1'b1;
	logic        m_only_ex    = 1'b0;
	logic [31:0] m_mask       = '0;
	logic [15:0] m_hv         = '0;

	// Decoder captures and per-job baselines
	logic [63:0] sc_got = '0;
	int          sc_cnt = 0;
	logic [15:0] dac_got = '0;
	int          dac_cnt = 0;
	logic [7:0]  hv_got[$];
	int          sc_base;
	int          dac_base;
	int          hv_base;
	int          wd_limit_ns = 0;

	tb_clock clock_i (.Clk_Out_2_All(Clk_Out_2_All), .rst_n_o(rst_n_i));

	sk_top dut_i (.*);

	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic expect_equal(input string name, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		assert (act_v === exp_v)
		else
		begin
			$display("FAILED %s expected %0h actual %0h", name, exp_v, act_v);
			abort_run();
		end
	endtask

	task automatic skip_cycles(input int n);
		repeat (n) @(negedge Clk_Out_2_All);
	endtask

	////////////////////
	// Serial decoders

	always @(posedge sr_ck_o)
	begin
		sc_got = {sc_got[62:0], sr_in_o};     // MSB arrives first
		sc_cnt++;
	end

	always @(negedge dac_sclk_o)
		if (!dac_cs_n_o)
		begin
			dac_got = {dac_got[14:0], dac_din_o};
			dac_cnt++;
		end

	initial
	begin : uart_rx
		logic [9:0] frame;
		forever
		begin
			@(negedge hv_tx_o);               // Start bit edge
			for (int b = 0; b < 10; b++)
			begin
				skip_cycles(b == 0 ? UART_DIV / 2 : UART_DIV);   // Mid-bit
				frame[b] = hv_tx_o;
			end
			assert (frame[0] == 1'b0 && frame[9] == 1'b1)
			else
			begin
				$display("UART byte %0d has a bad start or stop bit", hv_got.size());
				abort_run();
			end
			hv_got.push_back(frame[8:1]);
		end
	end

	////////////////////
	// Table building

	function automatic logic [63:0] image_now();
		return {m_chip_id, m_trig_delay, m_dac_trig, m_fb_cap, m_en_discri, m_only_ex, m_mask};
	endfunction

	task automatic add_entry(input string name, input logic [15:0] word, input int kind,
		input logic [63:0] exp_v);
		tbl_name.push_back(name);
		tbl_word.push_back(word);
		tbl_kind.push_back(kind);
		tbl_exp.push_back(exp_v);
	endtask

	// Field rules applied to the expected settings
	task automatic add_field(input string name, input logic [3:0] fld, input logic [7:0] val);
		case (fld)
			FLD_CHIP_ID:     m_chip_id         = val;
			FLD_TRIG_DELAY:  m_trig_delay      = val;
			FLD_DAC_TRIG_LO: m_dac_trig[7:0]   = val;
			FLD_DAC_TRIG_HI: m_dac_trig[9:8]   = val[1:0];
			FLD_MODE:        {m_only_ex, m_en_discri, m_fb_cap} = val[5:0];
			FLD_MASK3:       m_mask[31:24]     = val;
			FLD_MASK2:       m_mask[23:16]     = val;
			FLD_MASK1:       m_mask[15:8]      = val;
			FLD_MASK0:       m_mask[7:0]       = val;
			FLD_HV_HI:       m_hv[15:8]        = val;
			FLD_HV_LO:       m_hv[7:0]         = val;
			default:         ;                // Ignored index
		endcase
		add_entry(name, {OP_SET_FIELD, fld, val}, K_NONE, '0);
	endtask

	task automatic add_dac(input string name, input logic [11:0] code);
		add_entry(name, {OP_SET_DAC, code}, K_DAC, {48'h0, 4'b1000, code});
	endtask

	////////////////////
	// Job checks

	task automatic check_hv(input string name, input logic [15:0] val);
		string      digits;
		logic [7:0] exp_b[HV_BYTES];
		digits   = "0123456789ABCDEF";
		exp_b[0] = "H";
		exp_b[1] = "B";
		exp_b[2] = "V";
		for (int d = 0; d < 4; d++)
			exp_b[3+d] = digits[val[15-4*d -: 4]];   // Most significant digit first
		for (int i = 0; i < HV_BYTES; i++)
			expect_equal($sformatf("%s byte %0d", name, i), 64'(exp_b[i]),
				64'(hv_got[hv_base+i]));
	endtask

	task automatic check_job(input int idx);
		int kind;
		kind = tbl_kind[idx];
		expect_equal({tbl_name[idx], " sc bits"}, 64'(kind == K_SC ? SC_LEN : 0),
			64'(sc_cnt - sc_base));
		expect_equal({tbl_name[idx], " dac bits"}, 64'(kind == K_DAC ? 16 : 0),
			64'(dac_cnt - dac_base));
		expect_equal({tbl_name[idx], " hv bytes"}, 64'(kind == K_HV ? HV_BYTES : 0),
			64'(hv_got.size() - hv_base));
		if (kind == K_SC)
			expect_equal(tbl_name[idx], tbl_exp[idx], sc_got);
		if (kind == K_DAC)
			expect_equal(tbl_name[idx], tbl_exp[idx], 64'(dac_got));
		if (kind == K_HV)
			check_hv(tbl_name[idx], tbl_exp[idx][15:0]);
	endtask

	task automatic wait_ready();
		@(negedge Clk_Out_2_All);
		while (!cmd_ready_o)
			@(negedge Clk_Out_2_All);
	endtask

	////////////////////
	// Watchdog

	initial
	begin
		wait (wd_limit_ns != 0);
		#(wd_limit_ns);
		$display("Timeout: the DUT did not get through the command table in time");
		abort_run();
	end

	// Bound property failures end the run at once
	always @(negedge Clk_Out_2_All)
		if (dut_i.props_i.fail_cnt != 0)
		begin
			$display("A bound DUT property failed during the run");
			abort_run();
		end

	initial
	begin
		int pend;
		cmd_i       = '0;
		cmd_valid_i = 1'b0;
		pend        = -1;
		void'($urandom(32'h9ebb977e));
		add_entry("sc_reset", {OP_START_SC, 12'h000}, K_SC, image_now());
		add_field("chip_id", FLD_CHIP_ID, 8'hA5);
		add_field("trig_delay", FLD_TRIG_DELAY, 8'h3C);
		add_field("dac_trig_lo", FLD_DAC_TRIG_LO, 8'h5A);
		add_field("dac_trig_hi", FLD_DAC_TRIG_HI, 8'hFE);    // Only bits 1..0 land
		add_field("mode", FLD_MODE, 8'hEB);                  // fb_cap B, ext trig only
		add_field("mask3", FLD_MASK3, 8'($urandom));
		add_field("mask2", FLD_MASK2, 8'($urandom));
		add_field("mask1", FLD_MASK1, 8'($urandom));
		add_field("mask0", FLD_MASK0, 8'($urandom));
		add_field("hv_hi", FLD_HV_HI, 8'($urandom));
		add_field("hv_lo", FLD_HV_LO, 8'($urandom));
		for (int f = 11; f < 16; f++)
			add_field($sformatf("ignored_idx_%0d", f), 4'(f), 8'hFF);
		add_entry("unknown_op", 16'hF0FF, K_NONE, '0);
		add_entry("zero_op", 16'h0123, K_NONE, '0);
		add_entry("sc_fields", {OP_START_SC, 12'h000}, K_SC, image_now());
		add_dac("dac_rand", 12'($urandom));
		add_entry("hv_rand", {OP_START_HV, 12'h000}, K_HV, {48'h0, m_hv});
		add_field("chip_id_2", FLD_CHIP_ID, 8'h5C);
		add_field("mode_2", FLD_MODE, 8'h10);
		add_field("mask0_2", FLD_MASK0, 8'($urandom));
		add_entry("sc_after_hv", {OP_START_SC, 12'h000}, K_SC, image_now());
		add_dac("dac_fixed", 12'h9C3);
		add_field("trig_delay_2", FLD_TRIG_DELAY, 8'h01);
		add_entry("sc_after_dac", {OP_START_SC, 12'h000}, K_SC, image_now());
		add_field("hv_hi_2", FLD_HV_HI, 8'h0F);
		add_field("hv_lo_2", FLD_HV_LO, 8'h9A);
		add_entry("hv_fixed", {OP_START_HV, 12'h000}, K_HV, {48'h0, m_hv});
		wd_limit_ns = (tbl_word.size() + 2) * JOB_CYCLES * CLK_NS;

		do
			@(posedge Clk_Out_2_All);
		while (rst_n_i !== 1'b1);
		#1;

		// Serial lines parked and port ready right after reset
		expect_equal("reset_idle_levels", 64'(6'b000111),
			64'({sr_ck_o, sr_in_o, dac_sclk_o, dac_cs_n_o, hv_tx_o, cmd_ready_o}));

		for (int i = 0; i < tbl_word.size(); i++)
		begin
			cmd_i       = tbl_word[i];          // Held until accepted
			cmd_valid_i = 1'b1;
			wait_ready();
			if (pend >= 0)
				check_job(pend);                  // Previous job must be complete
			sc_base  = sc_cnt;
			dac_base = dac_cnt;
			hv_base  = hv_got.size();
			@(posedge Clk_Out_2_All);           // Transfer edge
			#1;
			cmd_valid_i = 1'b0;
			if (tbl_kind[i] != K_NONE)
			begin
				@(negedge Clk_Out_2_All);
				assert (!cmd_ready_o)
				else
				begin
					$display("%s: cmd_ready_o stayed high after the start command", tbl_name[i]);
					abort_run();
				end
				@(posedge Clk_Out_2_All);
				#1;
			end
			pend = i;
		end
		wait_ready();
		check_job(pend);

		if (dut_i.props_i.fail_cnt != 0)
		begin
			$display("A bound DUT property failed during the run");
			abort_run();
		end
		else
		begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

// ==== project.f ====
src/sk_cmd_pkg.sv
src/sk_cfg_pkg.sv
src/cmd_control.sv
src/sc_shifter.sv
src/dac_serial.sv
src/hv_uart.sv
src/sk_top.sv
tests/tb_clock.sv
tests/tb_properties.sv
tests/tb_top.sv

// ==== Makefile ====
# Verilator build and run for the front-end configuration testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_top
FILELIST  = project.f
OBJ_DIR   = obj_dir
# Let bound property failures reach the testbench's own end-of-run check
RUN_FLAGS = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)
